//--- compile.f
verilog/cache_pkg.sv
verilog/apb_cache_front.sv
verilog/cache_bank.sv
verilog/mem_arbiter.sv
verilog/cache_top.sv
test/cache_assert.sv
test/cache_tb.sv

//--- test/cache_trace.txt
# kind(r/w) addr wdata strb exp_rdata exp_err, all fields hex
# bank = addr[7:6], set = addr[11:8], tag = addr[31:12]
r 00000000 0000000000000000 00 9ac01f589ac01f58 0
r 00000000 0000000000000000 00 9ac01f589ac01f58 0
w 00000000 1122334455667788 0f 0000000000000000 0
r 00000000 0000000000000000 00 9ac01f5855667788 0
w 00000140 aaaabbbbccccdddd ff 0000000000000000 0
w 00000140 0123456789abcdef f0 0000000000000000 0
r 00000140 0000000000000000 00 01234567ccccdddd 0
w 000001c8 0f0f0f0f0f0f0f0f ff 0000000000000000 0
r 000001c8 0000000000000000 00 0f0f0f0f0f0f0f0f 0
w 80000010 5a5a5a5aa5a5a5a5 ff 0000000000000000 0
r 80000010 0000000000000000 00 5a5a5a5aa5a5a5a5 0
r 80000010 0000000000000000 00 5a5a5a5aa5a5a5a5 0
r 40000200 0000000000000000 00 0000000000000000 1
r 40000200 0000000000000000 00 0000000000000000 1
w 00001000 fedcba9876543210 ff 0000000000000000 0
r 00001000 0000000000000000 00 fedcba9876543210 0
r 00000000 0000000000000000 00 9ac01f5855667788 0
r 00000140 0000000000000000 00 01234567ccccdddd 0
r 00001000 0000000000000000 00 fedcba9876543210 0
r 000001c8 0000000000000000 00 0f0f0f0f0f0f0f0f 0

//--- test/cache_tb.sv
`timescale 1ns/100ps
module cache_tb;
  import cache_pkg::*;

  localparam int          clk_half     = 5;  // 10 ns clock.
  localparam int          reset_cycles = 5;
  localparam int          mem_latency  = 3;  // negedges from req to ready.
  localparam logic [31:0] seed         = 32'h9690f011;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [63:0] pwdata;
  logic [7:0]  pstrb;
  logic [63:0] prdata;
  logic        pready;
  logic        pslverr;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;

  int errors;
  int checks;
  int cycle_cnt;
  int cycle_limit;
  int wait_cnt;
  int line_reads, word_reads, word_writes;              // seen by the memory model.
  int exp_line_reads, exp_word_reads, exp_word_writes;  // predicted traffic.
  logic [31:0] last_waddr;
  logic [63:0] last_wdata;
  logic [7:0]  last_wmask;
  logic [31:0] wr_addr [$];  // words written so far with the newest last.
  logic [63:0] wr_data [$];
  logic [7:0]  t_kind [$];
  logic [31:0] t_addr [$];
  logic [63:0] t_wdata [$];
  logic [7:0]  t_strb [$];
  logic [63:0] t_rdata [$];
  logic        t_err [$];
  logic        model_valid [64];  // {bank, set} of the reference tags.
  logic [19:0] model_tag [64];

  cache_top dut0 (
    .clk (clk), .reset (reset), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .pstrb (pstrb), .prdata (prdata),
    .pready (pready), .pslverr (pslverr), .mem_req (mem_req), .mem_rsp (mem_rsp)
  );

  always #clk_half clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // latest written value of the word, else the fill pattern of its index.
  function automatic logic [63:0] word_value(input logic [31:0] addr);
    logic [31:0] x;
    for (int i = wr_addr.size() - 1; i >= 0; i--) begin
      if (wr_addr[i] == {addr[31:3], 3'b000}) return wr_data[i];
    end
    x = xorshift({3'b000, addr[31:3]} ^ seed);
    return {x, x};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] mask);
    logic [63:0] w;
    w = old;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) w[b*8 +: 8] = data[b*8 +: 8];  // byte lane enabled.
    end
    return w;
  endfunction

  task automatic serve_request();
    mem_rsp.err   = mem_req.addr[30];  // bit 30 marks a faulting region.
    mem_rsp.rdata = '0;
    case (mem_req.op)
      op_read_line: begin
        line_reads++;
        check_value(mem_req.addr[5:0], 6'd0, "line read address alignment");
        for (int i = 0; i < line_words; i++) begin
          if (!mem_rsp.err)
            mem_rsp.rdata[i*64 +: 64] = word_value({mem_req.addr[31:6], 6'd0} + 32'(i * 8));
        end
      end
      op_read_word: begin
        word_reads++;
        if (!mem_rsp.err) mem_rsp.rdata[63:0] = word_value(mem_req.addr);
      end
      op_write_word: begin
        word_writes++;
        last_waddr = mem_req.addr;
        last_wdata = mem_req.wdata;
        last_wmask = mem_req.wmask;
        if (!mem_rsp.err) begin
          wr_data.push_back(merge_bytes(word_value(mem_req.addr), mem_req.wdata, mem_req.wmask));
          wr_addr.push_back({mem_req.addr[31:3], 3'b000});
        end
      end
      default: begin
        errors++;
        $display("memory model saw an unknown opcode at %0t", $time);
      end
    endcase
    mem_rsp.ready = 1'b1;
  endtask

  // memory answers with a one-cycle ready a fixed number of cycles after req.
  always @(negedge clk) begin
    if (reset || mem_rsp.ready || !mem_req.req) begin
      mem_rsp.ready = 1'b0;
      mem_rsp.err   = 1'b0;
      wait_cnt      = 0;
    end else begin
      wait_cnt++;
      if (wait_cnt == mem_latency) serve_request();
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("run timed out after %0d cycles without finishing the trace", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one APB transfer with its latency counted in access-phase cycles.
  task automatic apb_access(input logic write, input logic [31:0] addr, input logic [63:0] wdata,
                            input logic [7:0] strb, output logic [63:0] rdata,
                            output logic err, output int latency);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(negedge clk);
    penable = 1'b1;
    latency = 0;
    do begin
      @(negedge clk);
      latency++;
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);  // transfer completes on the edge before.
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic load_trace();
    int fd;
    int n;
    string line;
    logic [7:0] kind;
    logic [63:0] f_addr, f_wdata, f_strb, f_rdata, f_err;
    fd = $fopen("test/cache_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the trace file test/cache_trace.txt");
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() < 2 || line[0] == "#") continue;  // blank or header line.
        n = $sscanf(line, "%c %h %h %h %h %h", kind, f_addr, f_wdata, f_strb, f_rdata, f_err);
        if (n != 6) begin
          errors++;
          $display("trace line could not be parsed: %s", line);
          continue;
        end
        t_kind.push_back(kind);
        t_addr.push_back(f_addr[31:0]);
        t_wdata.push_back(f_wdata);
        t_strb.push_back(f_strb[7:0]);
        t_rdata.push_back(f_rdata);
        t_err.push_back(f_err[0]);
      end
      $fclose(fd);
    end
  endtask

  // reference tags predict the hits and memory traffic of one access.
  task automatic predict(input logic [7:0] kind, input logic [31:0] addr, output logic hit);
    int idx;
    idx = {addr[7:6], addr[11:8]};
    hit = 1'b0;
    if (addr[31]) begin
      if (kind == "w") exp_word_writes++;
      else exp_word_reads++;
    end else if (kind == "w") begin
      exp_word_writes++;  // write-through without allocation.
    end else if (model_valid[idx] && model_tag[idx] == addr[31:12]) begin
      hit = 1'b1;
    end else begin
      exp_line_reads++;
      if (!addr[30]) begin
        model_valid[idx] = 1'b1;
        model_tag[idx]   = addr[31:12];
      end
    end
  endtask

  initial begin
    logic [63:0] rdata;
    logic        err;
    logic        hit;
    int          latency;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    mem_rsp = '0;
    foreach (model_valid[i]) model_valid[i] = 1'b0;
    load_trace();
    cycle_limit = t_addr.size() * 40 + 100;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < t_addr.size(); i++) begin
      predict(t_kind[i], t_addr[i], hit);
      apb_access(t_kind[i] == "w", t_addr[i], t_wdata[i], t_strb[i], rdata, err, latency);
      check_value(err, t_err[i], $sformatf("pslverr of access %0d", i));
      if (t_kind[i] == "r" && !t_err[i]) begin
        check_value(rdata, t_rdata[i], $sformatf("prdata of access %0d", i));
        check_value(rdata, word_value(t_addr[i]), $sformatf("memory word of access %0d", i));
      end
      if (hit) check_value(latency, 2, $sformatf("hit latency of access %0d", i));
      if (t_kind[i] == "w" && !t_err[i]) begin
        check_value(last_waddr, t_addr[i], $sformatf("write address of access %0d", i));
        check_value(last_wdata, t_wdata[i], $sformatf("write data of access %0d", i));
        check_value(last_wmask, t_strb[i], $sformatf("write mask of access %0d", i));
      end
      check_value(line_reads, exp_line_reads, $sformatf("line reads after access %0d", i));
      check_value(word_reads, exp_word_reads, $sformatf("word reads after access %0d", i));
      check_value(word_writes, exp_word_writes, $sformatf("word writes after access %0d", i));
    end
    $display("accesses %0d, checks %0d, errors %0d", t_addr.size(), checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- test/cache_assert.sv
`timescale 1ns/100ps
module cache_assert (
  input logic                clk,
  input logic                reset,
  input logic                psel,
  input logic                penable,
  input logic                pready,
  input cache_pkg::mem_req_t mem_req,
  input cache_pkg::mem_rsp_t mem_rsp
);
  import cache_pkg::*;

  // completion only inside an APB access phase.
  a_pready_phase: assert property (@(posedge clk) disable iff (reset)
    pready |-> psel && penable)
    else $error("pready outside access phase");

  // memory request frozen until memory answers.
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req.req && !mem_rsp.ready |=> $stable(mem_req))
    else $error("mem_req changed while waiting");

  a_req_drop: assert property (@(posedge clk) disable iff (reset)
    mem_req.req && mem_rsp.ready |=> !mem_req.req)
    else $error("mem_req.req held after ready");

endmodule

bind cache_top cache_assert assert0 (
  .clk     (clk),
  .reset   (reset),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .mem_req (mem_req),
  .mem_rsp (mem_rsp)
);

//--- verilog/cache_top.sv
`timescale 1ns/100ps
module cache_top #(
  parameter int num_banks     = 4,
  parameter int sets_per_bank = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [31:0]        paddr,
  input  logic [63:0]        pwdata,
  input  logic [7:0]         pstrb,
  output logic [63:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output cache_pkg::mem_req_t mem_req,
  input  cache_pkg::mem_rsp_t mem_rsp
);
  import cache_pkg::*;

  bank_req_t bank_req     [num_banks];  // front end to banks.
  bank_rsp_t bank_rsp     [num_banks];  // banks to front end.
  mem_req_t  bank_mem_req [num_banks];  // banks to arbiter.
  mem_rsp_t  bank_mem_rsp [num_banks];  // arbiter to banks.

  apb_cache_front #(
    .num_banks     (num_banks),
    .sets_per_bank (sets_per_bank)
  ) front0 (
    .clk      (clk),
    .reset    (reset),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pstrb    (pstrb),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .bank_req (bank_req),
    .bank_rsp (bank_rsp)
  );

  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    cache_bank #(
      .num_banks     (num_banks),
      .sets_per_bank (sets_per_bank)
    ) bank0 (
      .clk     (clk),
      .reset   (reset),
      .req     (bank_req[i]),
      .rsp     (bank_rsp[i]),
      .mem_req (bank_mem_req[i]),
      .mem_rsp (bank_mem_rsp[i])
    );
  end

  mem_arbiter #(
    .num_banks     (num_banks),
    .sets_per_bank (sets_per_bank)
  ) arb0 (
    .clk          (clk),
    .reset        (reset),
    .bank_mem_req (bank_mem_req),
    .bank_mem_rsp (bank_mem_rsp),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp)
  );

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/100ps
module mem_arbiter #(
  parameter int num_banks     = 4,
  parameter int sets_per_bank = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  cache_pkg::mem_req_t bank_mem_req [num_banks],
  output cache_pkg::mem_rsp_t bank_mem_rsp [num_banks],
  output cache_pkg::mem_req_t mem_req,
  input  cache_pkg::mem_rsp_t mem_rsp
);
  import cache_pkg::*;

  localparam int bank_bits = $clog2(num_banks);
  localparam int set_bits  = $clog2(sets_per_bank);

  logic                 busy_q;   // a transfer is in flight.
  logic [bank_bits-1:0] grant_q;  // bank holding the bus.
  logic [bank_bits-1:0] pick;     // lowest requesting bank.
  logic [bank_bits-1:0] grant;

  if (num_banks < 2 || num_banks != (1 << bank_bits) ||
      sets_per_bank != (1 << set_bits)) begin : g_param_check
    $fatal(1, "mem_arbiter: num_banks and sets_per_bank must be powers of two");
  end

  // fixed priority, lowest index wins.
  always_comb begin
    pick = '0;
    for (int i = num_banks - 1; i >= 0; i--) begin
      if (bank_mem_req[i].req) pick = bank_bits'(i);
    end
  end

  assign grant   = busy_q ? grant_q : pick;  // no extra cycle when free.
  assign mem_req = bank_mem_req[grant];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q  <= 1'b0;
      grant_q <= '0;
    end else begin
      busy_q  <= mem_req.req && !mem_rsp.ready;  // released on ready.
      grant_q <= grant;
    end
  end

  // only the granted bank sees ready.
  always_comb begin
    for (int i = 0; i < num_banks; i++) begin
      bank_mem_rsp[i]       = mem_rsp;
      bank_mem_rsp[i].ready = mem_rsp.ready && mem_req.req && (grant == i);
    end
  end

endmodule

//--- verilog/cache_bank.sv
`timescale 1ns/100ps
module cache_bank #(
  parameter int num_banks     = 4,
  parameter int sets_per_bank = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::bank_req_t req,
  output cache_pkg::bank_rsp_t rsp,
  output cache_pkg::mem_req_t  mem_req,
  input  cache_pkg::mem_rsp_t  mem_rsp
);
  import cache_pkg::*;

  localparam int bank_bits = $clog2(num_banks);
  localparam int set_bits  = $clog2(sets_per_bank);
  localparam int word_bits = $clog2(line_words);
  localparam int word_lsb  = offset_bits - word_bits;  // byte bits inside a word.
  localparam int tag_lsb   = offset_bits + bank_bits + set_bits;
  localparam int tag_bits  = 32 - tag_lsb;

  typedef enum logic [2:0] {
    idle,
    lookup,     // tag compare on the latched request.
    fill,       // line read outstanding.
    write_mem,  // write-through outstanding.
    bypass      // uncached word access outstanding.
  } state_t;

  state_t state;
  bank_req_t req_q;

  logic [line_bits-1:0] data_mem [sets_per_bank];
  logic [tag_bits-1:0]  tag_mem  [sets_per_bank];
  logic [sets_per_bank-1:0] valid_q;

  logic wr_hit_q;       // write hit seen in lookup.
  logic done_q;         // memory access finished last cycle.
  logic err_q;
  logic [63:0] rdata_q;

  logic [set_bits-1:0]  set_idx;
  logic [tag_bits-1:0]  tag;
  logic [word_bits-1:0] word_idx;
  logic [line_bits-1:0] cur_line;
  logic [line_bits-1:0] merged_line;
  logic hit;
  logic fill_en;
  logic merge_en;

  assign set_idx  = req_q.addr[offset_bits + bank_bits +: set_bits];
  assign tag      = req_q.addr[31:tag_lsb];
  assign word_idx = req_q.addr[word_lsb +: word_bits];
  assign cur_line = data_mem[set_idx];  // asynchronous array read.
  assign hit      = valid_q[set_idx] && (tag_mem[set_idx] == tag);

  assign fill_en  = (state == fill) && mem_rsp.ready && !mem_rsp.err;
  assign merge_en = (state == write_mem) && mem_rsp.ready && !mem_rsp.err && wr_hit_q;

  // store data laid over the cached line by byte strobe.
  always_comb begin
    merged_line = cur_line;
    for (int b = 0; b < 8; b++) begin
      if (req_q.wstrb[b]) merged_line[word_idx*64 + b*8 +: 8] = req_q.wdata[b*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= idle;
      valid_q <= '0;      // all lines invalid.
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        idle: begin
          if (req.valid) state <= req.addr[31] ? bypass : lookup;  // bit 31 is uncached.
        end
        lookup: begin
          if (req_q.write) state <= write_mem;  // every store goes to memory.
          else if (hit) state <= idle;          // hit answered this cycle.
          else state <= fill;
        end
        fill, write_mem, bypass: begin
          if (mem_rsp.ready) begin
            state  <= idle;
            done_q <= 1'b1;
          end
          if (fill_en) valid_q[set_idx] <= 1'b1;  // no install on error.
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && req.valid) req_q <= req;
    if (state == lookup) wr_hit_q <= hit;
    if (mem_rsp.ready) begin
      err_q   <= mem_rsp.err;
      rdata_q <= (state == fill) ? mem_rsp.rdata[word_idx*64 +: 64] : mem_rsp.rdata[63:0];
    end
    if (fill_en) begin
      data_mem[set_idx] <= mem_rsp.rdata;
      tag_mem[set_idx]  <= tag;
    end
    if (merge_en) data_mem[set_idx] <= merged_line;  // write hit updates the line.
  end

  // request held while waiting, drops the cycle after ready.
  always_comb begin
    mem_req.req   = (state == fill) || (state == write_mem) || (state == bypass);
    mem_req.op    = op_read_word;
    mem_req.addr  = req_q.addr;
    mem_req.wdata = req_q.wdata;
    mem_req.wmask = req_q.write ? req_q.wstrb : 8'h00;
    case (state)
      fill: begin
        mem_req.op   = op_read_line;
        mem_req.addr = {req_q.addr[31:offset_bits], {offset_bits{1'b0}}};  // line aligned.
      end
      write_mem: mem_req.op = op_write_word;
      bypass:    mem_req.op = req_q.write ? op_write_word : op_read_word;
      default: ;
    endcase
  end

  // hit data straight from the array, otherwise the registered result.
  always_comb begin
    rsp.ok    = done_q || (state == lookup && !req_q.write && hit);
    rsp.err   = done_q && err_q;
    rsp.rdata = done_q ? rdata_q : cur_line[word_idx*64 +: 64];
  end

endmodule

//--- verilog/apb_cache_front.sv
`timescale 1ns/100ps
module apb_cache_front #(
  parameter int num_banks     = 4,
  parameter int sets_per_bank = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [31:0]         paddr,
  input  logic [63:0]         pwdata,
  input  logic [7:0]          pstrb,
  output logic [63:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output cache_pkg::bank_req_t bank_req [num_banks],
  input  cache_pkg::bank_rsp_t bank_rsp [num_banks]
);
  import cache_pkg::*;

  localparam int bank_bits = $clog2(num_banks);
  localparam int set_bits  = $clog2(sets_per_bank);

  typedef enum logic [1:0] {
    idle,       // waiting for an APB setup phase.
    issue,      // request visible to the bank this cycle.
    wait_bank   // waiting for the bank's ok.
  } state_t;

  state_t               state;
  bank_req_t            req_q;   // captured APB access.
  logic [bank_bits-1:0] sel_q;   // decoded bank.

  // bank count and set count must be powers of two.
  if (num_banks < 2 || num_banks != (1 << bank_bits) ||
      sets_per_bank != (1 << set_bits)) begin : g_param_check
    $fatal(1, "apb_cache_front: num_banks and sets_per_bank must be powers of two");
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= idle;
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= 1'b0;  // single cycle completion.
      pslverr <= 1'b0;
      case (state)
        idle: if (psel && !penable) state <= issue;  // setup phase seen.
        issue: state <= wait_bank;                    // bank has latched it.
        wait_bank: begin
          if (bank_rsp[sel_q].ok) begin
            pready  <= 1'b1;
            pslverr <= bank_rsp[sel_q].err;
            state   <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // address and data are stable from setup onwards.
  always_ff @(posedge clk) begin
    if (state == idle && psel && !penable) begin
      req_q <= '{valid: 1'b1, write: pwrite, addr: paddr, wdata: pwdata, wstrb: pstrb};
      sel_q <= paddr[offset_bits +: bank_bits];  // bank select bits above the offset.
    end
    if (state == wait_bank && bank_rsp[sel_q].ok) prdata <= bank_rsp[sel_q].rdata;
  end

  // same payload to every bank, strobe only on the selected one.
  always_comb begin
    for (int i = 0; i < num_banks; i++) begin
      bank_req[i]       = req_q;
      bank_req[i].valid = (state == issue) && (sel_q == i);
    end
  end

endmodule

//--- verilog/cache_pkg.sv
package cache_pkg;

  localparam int line_words  = 8;    // 64-bit words per line.
  localparam int line_bits   = 512;  // full line width.
  localparam int offset_bits = 6;    // byte offset inside a line.

  // memory bus opcodes.
  typedef enum logic [1:0] {
    op_read_line,   // cached fill of a whole line.
    op_read_word,   // uncached single word read.
    op_write_word   // single word write with byte mask.
  } mem_op_t;

  typedef struct packed {
    logic        valid;  // one-cycle request strobe.
    logic        write;  // 1 = store.
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wstrb;  // byte enables for stores.
  } bank_req_t;

  typedef struct packed {
    logic        ok;     // one-cycle completion pulse.
    logic        err;    // valid with ok.
    logic [63:0] rdata;
  } bank_rsp_t;

  typedef struct packed {
    logic        req;    // held until ready.
    mem_op_t     op;
    logic [31:0] addr;   // line aligned for op_read_line.
    logic [63:0] wdata;
    logic [7:0]  wmask;
  } mem_req_t;

  typedef struct packed {
    logic                 ready;  // one-cycle pulse.
    logic                 err;    // valid with ready.
    logic [line_bits-1:0] rdata;  // word reads use the low 64 bits.
  } mem_rsp_t;

endpackage
